/* Makefile */
# Verilator flow for the UART testbench
TOP := uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

# Error limit raised so a bound assertion reaches the testbench's failure path
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f tb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* tb.f */
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_sva.sv
uart_tb.sv

/* uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Frame format of the serial port

`define UART_DATA_BITS  8   // Data bits per frame, sent MSB first
`define UART_STOP_BITS  2   // Stop bits after the data

// Clock cycles per bit on the line
// i_rate already runs at this multiple of the bit rate,
// and the 4-bit cycle counters in both blocks assume 16
`define UART_OVERSAMPLE 16

`endif

/* uart_pkg.sv */
package uart_pkg;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,    // Line high, waiting for start
        TX_START,   // Start bit
        TX_DATA,    // Data bits, MSB first
        TX_STOP     // Stop bits
    } tx_state_e;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,    // Waiting for a falling edge
        RX_START,   // Checking the start bit at mid-bit
        RX_DATA,    // Sampling data bits
        RX_STOP     // Sampling stop bits
    } rx_state_e;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx #(
    parameter int DATA_BITS = `UART_DATA_BITS,
    parameter int STOP_BITS = `UART_STOP_BITS
) (
    input  logic                 i_rate,
    input  logic                 i_reset,
    input  logic                 i_bit_rx,
    output logic [DATA_BITS-1:0] o_data_out,
    output logic                 o_rx_done,
    output logic                 o_frame_error
);
    import uart_pkg::*;

    localparam int OVS    = `UART_OVERSAMPLE;
    localparam int BIT_W  = $clog2(DATA_BITS + 1);
    localparam int STOP_W = $clog2(STOP_BITS + 1);

    localparam logic [3:0]        TICK_LAST = 4'(OVS - 1);
    localparam logic [3:0]        TICK_HALF = 4'(OVS / 2 - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_BITS - 1);
    localparam logic [STOP_W-1:0] STOP_LAST = STOP_W'(STOP_BITS - 1);

    rx_state_e            state;
    logic [1:0]           rx_sync;
    logic                 rx_s;
    logic                 rx_prev;
    logic                 start_edge;
    logic [3:0]           tick;
    logic [BIT_W-1:0]     bit_cnt;
    logic [STOP_W-1:0]    stop_cnt;
    logic                 stop_err;    // Some earlier stop sample was low
    logic [DATA_BITS-1:0] shreg;
    logic                 mid_start;
    logic                 sample;

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_prev && !rx_s;
    assign mid_start  = (state == RX_START) && (tick == TICK_HALF);
    assign sample     = (state == RX_DATA || state == RX_STOP) && (tick == TICK_LAST);

    // Synchronizer and edge detect, idle high
    always_ff @(posedge i_rate or negedge i_reset) begin
        if (!i_reset) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], i_bit_rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge i_rate or negedge i_reset) begin
        if (!i_reset) begin
            state         <= RX_IDLE;
            tick          <= '0;
            bit_cnt       <= '0;
            stop_cnt      <= '0;
            stop_err      <= 1'b0;
            o_data_out    <= '0;
            o_rx_done     <= 1'b0;
            o_frame_error <= 1'b0;
        end else begin
            o_rx_done     <= 1'b0;
            o_frame_error <= 1'b0;

            if (state == RX_IDLE || mid_start || sample) begin
                tick <= '0;
            end else begin
                tick <= tick + 4'd1;
            end

            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        if (!rx_s) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end else begin
                            state <= RX_IDLE;   // Glitch, not a start bit
                        end
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        if (bit_cnt == BIT_LAST) begin
                            state    <= RX_STOP;
                            stop_cnt <= '0;
                            stop_err <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        if (stop_cnt == STOP_LAST) begin
                            state <= RX_IDLE;
                            if (stop_err || !rx_s) begin
                                o_frame_error <= 1'b1;
                            end else begin
                                o_rx_done  <= 1'b1;
                                o_data_out <= shreg;
                            end
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                            stop_err <= stop_err || !rx_s;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_rate) begin
        if (state == RX_DATA && sample) begin
            shreg <= (shreg << 1) | DATA_BITS'(rx_s);   // MSB arrives first
        end
    end

endmodule

/* uart_sva.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_sva #(
    parameter int DATA_BITS = `UART_DATA_BITS,
    parameter int STOP_BITS = `UART_STOP_BITS
) (
    input logic i_rate,
    input logic i_reset,
    input logic i_serial,
    input logic i_tx_done,
    input logic i_rx_done,
    input logic i_frame_error
);

    localparam int OVS       = `UART_OVERSAMPLE;
    localparam int FRAME     = OVS * (1 + DATA_BITS + STOP_BITS);
    localparam int STOP_SPAN = OVS * STOP_BITS;

    int   fail_count = 0;   // Read by the testbench
    int   low_cnt;          // Cycles of the current frame so far
    logic idle_outputs;

    assign idle_outputs = i_serial && i_tx_done && !i_rx_done && !i_frame_error;

    always_ff @(posedge i_rate or negedge i_reset) begin
        if (!i_reset) begin
            low_cnt <= 0;
        end else if (!i_tx_done) begin
            low_cnt <= low_cnt + 1;
        end else begin
            low_cnt <= 0;
        end
    end

    // Line idle and receiver quiet while in reset and on release
    a_reset_values: assert property (@(posedge i_rate) !i_reset |-> idle_outputs)
        else begin
            fail_count = fail_count + 1;
            $error("outputs not at reset values during reset");
        end

    a_after_reset: assert property (@(posedge i_rate) $rose(i_reset) |-> idle_outputs)
        else begin
            fail_count = fail_count + 1;
            $error("outputs not idle right after reset");
        end

    a_frame_length: assert property (@(posedge i_rate) disable iff (!i_reset)
        $rose(i_tx_done) |-> low_cnt == FRAME)
        else begin
            fail_count = fail_count + 1;
            $error("o_tx_done low for %0d cycles", low_cnt);
        end

    a_frame_bound: assert property (@(posedge i_rate) disable iff (!i_reset)
        !i_tx_done |-> low_cnt < FRAME)
        else begin
            fail_count = fail_count + 1;
            $error("frame runs past its length");
        end

    a_start_bit: assert property (@(posedge i_rate) disable iff (!i_reset)
        (!i_tx_done && low_cnt < OVS) |-> !i_serial)
        else begin
            fail_count = fail_count + 1;
            $error("start bit not low in cycle %0d", low_cnt);
        end

    a_stop_bits: assert property (@(posedge i_rate) disable iff (!i_reset)
        (!i_tx_done && low_cnt >= FRAME - STOP_SPAN) |-> i_serial)
        else begin
            fail_count = fail_count + 1;
            $error("stop bits not high in cycle %0d", low_cnt);
        end

    a_rx_exclusive: assert property (@(posedge i_rate) disable iff (!i_reset)
        !(i_rx_done && i_frame_error))
        else begin
            fail_count = fail_count + 1;
            $error("o_rx_done and o_frame_error high together");
        end

    a_rx_done_pulse: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_rx_done |=> !i_rx_done)
        else begin
            fail_count = fail_count + 1;
            $error("o_rx_done high for more than one cycle");
        end

    a_frame_error_pulse: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_frame_error |=> !i_frame_error)
        else begin
            fail_count = fail_count + 1;
            $error("o_frame_error high for more than one cycle");
        end

endmodule

bind uart_top uart_sva #(
    .DATA_BITS (DATA_BITS),
    .STOP_BITS (STOP_BITS)
) u_sva (
    .i_rate        (i_rate),
    .i_reset       (i_reset),
    .i_serial      (o_serial),
    .i_tx_done     (o_tx_done),
    .i_rx_done     (o_rx_done),
    .i_frame_error (o_frame_error)
);

/* uart_tb.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

    localparam int W          = `UART_DATA_BITS;
    localparam int STOP       = `UART_STOP_BITS;
    localparam int OVS        = `UART_OVERSAMPLE;
    localparam int FRAME      = OVS * (1 + W + STOP);
    localparam int NUM_RANDOM = 30;
    // Random frames, the two frames of the busy test, the two hand-built frames
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + 4) * FRAME * 3 / 2;

    logic         i_rate;
    logic         i_reset;
    logic         i_tx_start;
    logic [W-1:0] i_tx_data;
    logic         serial_out;
    logic         tx_done;
    logic         serial_in;
    logic [W-1:0] rx_data;
    logic         rx_done;
    logic         frame_error;

    logic         loop_sel;     // 1 feeds o_serial back to i_serial
    logic         tb_line;
    logic [31:0]  lfsr;
    logic [W-1:0] sent_q[$];
    logic [W-1:0] exp_word;
    logic [W-1:0] word_a;
    logic [W-1:0] word_b;
    int           cycle_count;
    int           rx_done_seen;
    int           err_seen;
    int           done_before;

    assign serial_in = loop_sel ? serial_out : tb_line;

    uart_top DUT (
        .i_rate        (i_rate),
        .i_reset       (i_reset),
        .i_tx_start    (i_tx_start),
        .i_tx_data     (i_tx_data),
        .o_serial      (serial_out),
        .o_tx_done     (tx_done),
        .i_serial      (serial_in),
        .o_rx_data     (rx_data),
        .o_rx_done     (rx_done),
        .o_frame_error (frame_error)
    );

    initial i_rate = 1'b0;
    always #20 i_rate = ~i_rate;

    task automatic abort_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per data bit
    task automatic draw_word(output logic [W-1:0] w);
        w = '0;
        for (int i = 0; i < W; i++) begin
            lfsr = lfsr_step(lfsr);
            w = (w << 1) | W'(lfsr[0]);
        end
    endtask

    task automatic step();
        @(posedge i_rate);
        #1;
    endtask

    task automatic send_word(input logic [W-1:0] w);
        while (!tx_done) begin
            step();
        end
        i_tx_data  = w;
        i_tx_start = 1'b1;
        sent_q.push_back(w);
        step();
        i_tx_start = 1'b0;
        while (!tx_done) begin
            step();
        end
    endtask

    task automatic hold_line(input logic level);
        tb_line = level;
        repeat (OVS) step();
    endtask

    task automatic drive_frame(input logic [W-1:0] w, input logic first_stop);
        hold_line(1'b0);
        for (int i = W - 1; i >= 0; i--) begin
            hold_line(w[i]);
        end
        hold_line(first_stop);
        for (int i = 1; i < STOP; i++) begin
            hold_line(1'b1);
        end
        hold_line(1'b1);   // Idle gap
    endtask

    task automatic wait_rx_drained();
        while (sent_q.size() != 0) begin
            step();
        end
    endtask

    // Scoreboard sampled away from the clock edge
    always @(negedge i_rate) begin
        if (frame_error) begin
            err_seen = err_seen + 1;
        end
        if (rx_done) begin
            rx_done_seen = rx_done_seen + 1;
            if (sent_q.size() == 0) begin
                abort_run("receiver reported a word that was never sent");
            end else begin
                exp_word = sent_q.pop_front();
                assert (rx_data == exp_word) else begin
                    $display("FAIL %0d ns: received %h, expected %h",
                             $time, rx_data, exp_word);
                    abort_run("received word does not match");
                end
            end
        end
    end

    always @(negedge i_rate) begin
        if (DUT.u_sva.fail_count != 0) begin
            abort_run("a bound assertion in uart_sva failed");
        end
    end

    always @(posedge i_rate) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout waiting for the DUT");
        end
    end

    initial begin
        i_reset      = 1'b0;
        i_tx_start   = 1'b0;
        i_tx_data    = '0;
        tb_line      = 1'b1;
        loop_sel     = 1'b1;
        lfsr         = 32'hfb2e4eaf;
        cycle_count  = 0;
        rx_done_seen = 0;
        err_seen     = 0;
        done_before  = 0;
        repeat (5) @(posedge i_rate);
        #1;
        i_reset = 1'b1;
        step();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            draw_word(word_a);
            send_word(word_a);
        end
        wait_rx_drained();

        // Start and new data mid-frame while the latched word goes out
        draw_word(word_a);
        word_b = ~word_a;   // Every bit differs from the word in flight
        i_tx_data  = word_a;
        i_tx_start = 1'b1;
        sent_q.push_back(word_a);
        step();
        i_tx_start = 1'b0;
        repeat (FRAME / 2) step();
        i_tx_data  = word_b;
        i_tx_start = 1'b1;
        sent_q.push_back(word_b);
        while (!tx_done) begin
            step();
        end
        step();
        i_tx_start = 1'b0;
        while (!tx_done) begin
            step();
        end
        wait_rx_drained();

        // Hand-built frames
        loop_sel = 1'b0;
        step();
        done_before = rx_done_seen;
        draw_word(word_a);
        drive_frame(word_a, 1'b0);
        while (err_seen == 0) begin
            step();
        end
        assert (err_seen == 1 && rx_done_seen == done_before) else begin
            $display("FAIL %0d ns: bad stop bit gave %0d errors and %0d words",
                     $time, err_seen, rx_done_seen - done_before);
            abort_run("framing error not reported as one error pulse");
        end

        draw_word(word_b);
        sent_q.push_back(word_b);
        drive_frame(word_b, 1'b1);
        wait_rx_drained();
        assert (rx_done_seen == NUM_RANDOM + 3 && err_seen == 1) else begin
            $display("FAIL %0d ns: %0d words and %0d errors received",
                     $time, rx_done_seen, err_seen);
            abort_run("wrong number of receiver results");
        end

        repeat (4) step();
        if (DUT.u_sva.fail_count != 0) begin
            abort_run("a bound assertion in uart_sva failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* uart_top.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top #(
    parameter int DATA_BITS = `UART_DATA_BITS,
    parameter int STOP_BITS = `UART_STOP_BITS
) (
    input  logic                 i_rate,
    input  logic                 i_reset,
    // Transmit side
    input  logic                 i_tx_start,
    input  logic [DATA_BITS-1:0] i_tx_data,
    output logic                 o_serial,
    output logic                 o_tx_done,
    // Receive side
    input  logic                 i_serial,
    output logic [DATA_BITS-1:0] o_rx_data,
    output logic                 o_rx_done,
    output logic                 o_frame_error
);

    uart_tx #(
        .DATA_BITS (DATA_BITS),
        .STOP_BITS (STOP_BITS)
    ) u_tx (
        .i_rate     (i_rate),
        .i_reset    (i_reset),
        .i_tx_start (i_tx_start),
        .i_data_in  (i_tx_data),
        .o_bit_tx   (o_serial),
        .o_tx_done  (o_tx_done)
    );

    // Independent of the transmitter, loopback is closed outside
    uart_rx #(
        .DATA_BITS (DATA_BITS),
        .STOP_BITS (STOP_BITS)
    ) u_rx (
        .i_rate        (i_rate),
        .i_reset       (i_reset),
        .i_bit_rx      (i_serial),
        .o_data_out    (o_rx_data),
        .o_rx_done     (o_rx_done),
        .o_frame_error (o_frame_error)
    );

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx #(
    parameter int DATA_BITS = `UART_DATA_BITS,
    parameter int STOP_BITS = `UART_STOP_BITS
) (
    input  logic                 i_rate,
    input  logic                 i_reset,
    input  logic                 i_tx_start,
    input  logic [DATA_BITS-1:0] i_data_in,
    output logic                 o_bit_tx,
    output logic                 o_tx_done
);
    import uart_pkg::*;

    localparam int OVS    = `UART_OVERSAMPLE;
    localparam int BIT_W  = $clog2(DATA_BITS + 1);
    localparam int STOP_W = $clog2(STOP_BITS + 1);

    localparam logic [3:0]        TICK_LAST = 4'(OVS - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_BITS - 1);
    localparam logic [STOP_W-1:0] STOP_LAST = STOP_W'(STOP_BITS - 1);

    tx_state_e            state;
    logic [3:0]           tick;       // Cycle within the current bit
    logic [BIT_W-1:0]     bit_cnt;
    logic [STOP_W-1:0]    stop_cnt;
    logic [DATA_BITS-1:0] shreg;
    logic                 bit_end;
    logic                 load;

    assign bit_end = (tick == TICK_LAST);
    assign load    = (state == TX_IDLE) && i_tx_start;

    always_ff @(posedge i_rate or negedge i_reset) begin
        if (!i_reset) begin
            state    <= TX_IDLE;
            tick     <= '0;
            bit_cnt  <= '0;
            stop_cnt <= '0;
        end else begin
            if (state == TX_IDLE || bit_end) begin
                tick <= '0;
            end else begin
                tick <= tick + 4'd1;
            end

            case (state)
                TX_IDLE: begin
                    if (i_tx_start) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_LAST) begin
                            state    <= TX_STOP;
                            stop_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (stop_cnt == STOP_LAST) begin
                            state <= TX_IDLE;   // Frame complete
                        end else begin
                            stop_cnt <= stop_cnt + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Word is captured once per frame so i_data_in may change freely while busy
    always_ff @(posedge i_rate) begin
        if (load) begin
            shreg <= i_data_in;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= shreg << 1;   // Next bit into MSB position
        end
    end

    always_comb begin
        case (state)
            TX_IDLE: begin
                o_bit_tx  = 1'b1;
                o_tx_done = 1'b1;
            end
            TX_START: begin
                o_bit_tx  = 1'b0;
                o_tx_done = 1'b0;
            end
            TX_DATA: begin
                o_bit_tx  = shreg[DATA_BITS-1];
                o_tx_done = 1'b0;
            end
            TX_STOP: begin
                o_bit_tx  = 1'b1;
                o_tx_done = 1'b0;
            end
            default: begin
                o_bit_tx  = 1'b1;
                o_tx_done = 1'b1;
            end
        endcase
    end

endmodule
